//--- test/rsrvs_trace.txt
# name rst flush padv taking op opc rfa1 rfb1 haz_a1 haz_b1 wb_tag result1 result2
# then expected op_any op opc rfa1 rfb1 unit_free; hazards are hex {d1 d2 tag}
issue 0 0 1 0 3 1 11111111 22222222 00 00 0 00000000 00000000 1 3 1 11111111 22222222 1
issue 0 0 0 1 0 0 00000000 00000000 00 00 0 00000000 00000000 0 0 0 00000000 00000000 1
backpress 0 0 1 0 5 2 aaaa0001 bbbb0001 00 00 0 00000000 00000000 1 5 2 aaaa0001 bbbb0001 1
backpress 0 0 1 0 6 3 aaaa0002 bbbb0002 00 00 0 00000000 00000000 1 5 2 aaaa0001 bbbb0001 0
backpress 0 0 0 0 0 0 00000000 00000000 00 00 0 00000000 00000000 1 5 2 aaaa0001 bbbb0001 0
backpress 0 0 0 1 0 0 00000000 00000000 00 00 0 00000000 00000000 1 6 3 aaaa0002 bbbb0002 1
backpress 0 0 0 1 0 0 00000000 00000000 00 00 0 00000000 00000000 0 0 0 00000000 00000000 1
fwd_a1 0 0 1 0 7 0 00000000 0000bbbb 15 00 0 00000000 00000000 0 0 0 00000000 00000000 0
fwd_a1 0 0 0 0 0 0 00000000 00000000 00 00 2 deadbeef 00000000 0 0 0 00000000 00000000 0
fwd_a1 0 0 0 0 0 0 00000000 00000000 00 00 5 12345678 99999999 1 7 0 12345678 0000bbbb 1
fwd_a1 0 0 0 1 0 0 00000000 00000000 00 00 0 00000000 00000000 0 0 0 00000000 00000000 1
fwd_b1 0 0 1 0 9 1 0000aaaa 00000000 00 0b 0 00000000 00000000 0 0 0 00000000 00000000 0
fwd_b1 0 0 0 0 0 0 00000000 00000000 00 00 6 00000000 55555555 0 0 0 00000000 00000000 0
fwd_b1 0 0 0 0 0 0 00000000 00000000 00 00 1 00000000 66666666 0 0 0 00000000 00000000 0
fwd_b1 0 0 0 0 0 0 00000000 00000000 00 00 3 77777777 cafef00d 1 9 1 0000aaaa cafef00d 1
fwd_b1 0 0 0 1 0 0 00000000 00000000 00 00 0 00000000 00000000 0 0 0 00000000 00000000 1
flush 0 0 1 0 2 0 00000001 00000002 00 00 0 00000000 00000000 1 2 0 00000001 00000002 1
flush 0 0 1 0 4 1 00000003 00000004 00 00 0 00000000 00000000 1 2 0 00000001 00000002 0
flush 0 1 0 0 0 0 00000000 00000000 00 00 0 00000000 00000000 0 0 0 00000000 00000000 1
flush 0 0 0 0 0 0 00000000 00000000 00 00 0 00000000 00000000 0 0 0 00000000 00000000 1
reset 0 0 1 0 8 2 00000010 00000020 00 00 0 00000000 00000000 1 8 2 00000010 00000020 1
reset 0 0 1 0 a 3 00000030 00000040 15 00 0 00000000 00000000 1 8 2 00000010 00000020 0
reset 1 0 0 0 0 0 00000000 00000000 00 00 0 00000000 00000000 0 0 0 00000000 00000000 1
reset 0 0 0 0 0 0 00000000 00000000 00 00 5 aaaaaaaa bbbbbbbb 0 0 0 00000000 00000000 1

//--- rsrvs.f
+incdir+common
common/rsrvs_pkg.sv
rsrvs/rsrvs_operand_slot.sv
rsrvs/rsrvs_busy_stage.sv
rsrvs/rsrvs_exec_stage.sv
rsrvs/rsrvs.sv
test/rsrvs_tb.sv

//--- Makefile
# reservation station simulation with Verilator

.PHONY: help test clean

help:
	@echo "targets:"
	@echo "  test   build and run the testbench"
	@echo "  clean  remove the build directory"
	@echo "  help   show this list"

test:
	verilator --binary -f rsrvs.f --top-module rsrvs_tb
	@out="$$(./obj_dir/Vrsrvs_tb)"; echo "$$out"; \
	echo "$$out" | grep -qx "All checks passed"

clean:
	rm -rf obj_dir

//--- test/rsrvs_tb.sv
// reservation station testbench

`timescale 1ns/1ps
`default_nettype none

module rsrvs_tb;

  // name plus 13 input and 6 expected columns
  localparam int TRACE_FIELDS = 20;
  localparam int MAX_LINES    = 500;
  localparam int FREE_TIMEOUT = 10;

  logic                  cpu_clk;
  logic                  rst_i;
  logic                  pipeline_flush_i;
  logic                  padv_rsrvs_i;
  logic                  taking_op_i;
  rsrvs_pkg::dcod_req_t  dcod_req_i;
  rsrvs_pkg::hazard_t    hazard_a1_i;
  rsrvs_pkg::hazard_t    hazard_b1_i;
  rsrvs_pkg::wrbk_t      wrbk_i;
  rsrvs_pkg::exec_cmd_t  exec_cmd_o;
  logic                  unit_free_o;

  ////////////////////////////////////////////////////////////
  // trace line fields
  ////////////////////////////////////////////////////////////

  string               line;
  string               name;
  int                  fd;
  int                  nread;
  int                  nlines;
  logic                t_rst;
  logic                t_flush;
  logic                t_padv;
  logic                t_taking;
  rsrvs_pkg::op_t      t_op;
  rsrvs_pkg::opc_t     t_opc;
  rsrvs_pkg::operand_t t_rfa1;
  rsrvs_pkg::operand_t t_rfb1;
  logic [4:0]          t_haz_a1;
  logic [4:0]          t_haz_b1;
  rsrvs_pkg::extadr_t  t_tag;
  rsrvs_pkg::operand_t t_res1;
  rsrvs_pkg::operand_t t_res2;
  logic                e_any;
  rsrvs_pkg::op_t      e_op;
  rsrvs_pkg::opc_t     e_opc;
  rsrvs_pkg::operand_t e_rfa1;
  rsrvs_pkg::operand_t e_rfb1;
  logic                e_free;

  // expectation of the line driven one edge earlier
  string                exp_name;
  logic                 exp_valid;
  rsrvs_pkg::exec_cmd_t exp_cmd;
  logic                 exp_free;

  // per test and overall counts
  string cur_test;
  int    test_checks;
  int    test_errors;
  int    n_tests;
  int    n_checks;
  int    n_errors;

  rsrvs u_rsrvs (
    .cpu_clk          (cpu_clk),
    .rst_i            (rst_i),
    .pipeline_flush_i (pipeline_flush_i),
    .padv_rsrvs_i     (padv_rsrvs_i),
    .taking_op_i      (taking_op_i),
    .dcod_req_i       (dcod_req_i),
    .hazard_a1_i      (hazard_a1_i),
    .hazard_b1_i      (hazard_b1_i),
    .wrbk_i           (wrbk_i),
    .exec_cmd_o       (exec_cmd_o),
    .unit_free_o      (unit_free_o)
  );

  // 100 ns period
  always #50 cpu_clk = ~cpu_clk;

  ////////////////////////////////////////////////////////////
  // checks
  ////////////////////////////////////////////////////////////

  task automatic check_field(input string field, input logic [31:0] expected,
                             input logic [31:0] actual);
    test_checks++;
    if (actual !== expected) begin
      $display("FAILED %s %s expected %h actual %h", exp_name, field, expected, actual);
      test_errors++;
    end
  endtask

  // one summary line per finished test
  task automatic close_test();
    if (cur_test != "") begin
      if (test_errors == 0) begin
        $display("test %s ok, %0d checks", cur_test, test_checks);
      end else begin
        $display("test %s wrong, %0d of %0d checks", cur_test, test_errors, test_checks);
      end
      n_tests++;
      n_checks += test_checks;
      n_errors += test_errors;
    end
    test_checks = 0;
    test_errors = 0;
  endtask

  task automatic check_outputs();
    if (exp_name != cur_test) begin
      close_test();
      cur_test = exp_name;
    end
    check_field("op_any", 32'(exp_cmd.op_any), 32'(exec_cmd_o.op_any));
    check_field("unit_free", 32'(exp_free), 32'(unit_free_o));
    // payload only counts with op_any
    if (exp_cmd.op_any) begin
      check_field("op", 32'(exp_cmd.op), 32'(exec_cmd_o.op));
      check_field("opc", 32'(exp_cmd.opc), 32'(exec_cmd_o.opc));
      check_field("rfa1", exp_cmd.rfa1, exec_cmd_o.rfa1);
      check_field("rfb1", exp_cmd.rfb1, exec_cmd_o.rfb1);
    end
  endtask

  ////////////////////////////////////////////////////////////
  // stimulus
  ////////////////////////////////////////////////////////////

  task automatic apply_line();
    @(posedge cpu_clk);
    rst_i            <= t_rst;
    pipeline_flush_i <= t_flush;
    padv_rsrvs_i     <= t_padv;
    taking_op_i      <= t_taking;
    dcod_req_i       <= {t_op, t_opc, t_rfa1, t_rfb1};
    hazard_a1_i      <= t_haz_a1;
    hazard_b1_i      <= t_haz_b1;
    wrbk_i           <= {t_tag, t_res1, t_res2};
    // this edge consumed the previous line
    @(negedge cpu_clk);
    if (exp_valid) begin
      check_outputs();
    end
    exp_name  = name;
    exp_valid = 1'b1;
    exp_cmd   = {e_any, e_op, e_opc, e_rfa1, e_rfb1};
    exp_free  = e_free;
  endtask

  task automatic wait_unit_free();
    int cycles;
    cycles = 0;
    while (unit_free_o !== 1'b1 && cycles < FREE_TIMEOUT) begin
      @(negedge cpu_clk);
      cycles++;
    end
    if (unit_free_o !== 1'b1) begin
      $display("error: station not free %0d cycles after reset", FREE_TIMEOUT);
      n_errors++;
    end
  endtask

  initial begin
    cpu_clk          = 1'b0;
    rst_i            <= 1'b1;
    pipeline_flush_i <= 1'b0;
    padv_rsrvs_i     <= 1'b0;
    taking_op_i      <= 1'b0;
    dcod_req_i       <= '0;
    hazard_a1_i      <= '0;
    hazard_b1_i      <= '0;
    wrbk_i           <= '0;
    exp_valid        = 1'b0;
    cur_test         = "";
    test_checks      = 0;
    test_errors      = 0;
    n_tests          = 0;
    n_checks         = 0;
    n_errors         = 0;
    // three reset cycles
    repeat (3) @(posedge cpu_clk);
    rst_i <= 1'b0;
    wait_unit_free();

    fd = $fopen("test/rsrvs_trace.txt", "r");
    if (fd == 0) begin
      $display("error: cannot open trace file test/rsrvs_trace.txt");
      n_errors++;
    end else begin
      nlines = 0;
      while (!$feof(fd) && nlines < MAX_LINES) begin
        line  = "";
        nread = $fgets(line, fd);
        nlines++;
        // comment lines stop matching after the first token
        nread = $sscanf(line,
                        "%s %h %h %h %h %h %h %h %h %h %h %h %h %h %h %h %h %h %h %h",
                        name, t_rst, t_flush, t_padv, t_taking, t_op, t_opc,
                        t_rfa1, t_rfb1, t_haz_a1, t_haz_b1, t_tag, t_res1, t_res2,
                        e_any, e_op, e_opc, e_rfa1, e_rfb1, e_free);
        if (nread == TRACE_FIELDS) begin
          apply_line();
        end
      end
      if (nlines >= MAX_LINES) begin
        $display("error: trace has more than %0d lines", MAX_LINES);
        n_errors++;
      end
      $fclose(fd);
      // last line still in flight
      @(posedge cpu_clk);
      @(negedge cpu_clk);
      if (exp_valid) begin
        check_outputs();
      end
      close_test();
    end

    $display("tests %0d, checks %0d, errors %0d", n_tests, n_checks, n_errors);
    if (n_errors == 0 && n_tests > 0) begin
      $display("All checks passed");
    end else begin
      $display("Checks failed");
    end
    $finish;
  end

endmodule

`default_nettype wire

//--- rsrvs/rsrvs.sv
// two-tap reservation station

`timescale 1ns/1ps
`default_nettype none

module rsrvs (
  // clock and reset
  input  logic                  cpu_clk,
  input  logic                  rst_i,
  // pipeline control
  input  logic                  pipeline_flush_i,
  input  logic                  padv_rsrvs_i,
  // unit accepts the EXECUTE contents
  input  logic                  taking_op_i,
  // from decode
  input  rsrvs_pkg::dcod_req_t  dcod_req_i,
  input  rsrvs_pkg::hazard_t    hazard_a1_i,
  input  rsrvs_pkg::hazard_t    hazard_b1_i,
  // write-back snoop
  input  rsrvs_pkg::wrbk_t      wrbk_i,
  // to the unit
  output rsrvs_pkg::exec_cmd_t  exec_cmd_o,
  // BUSY is empty
  output logic                  unit_free_o
);

  ////////////////////////////////////////////////////////////
  // internal wires
  ////////////////////////////////////////////////////////////

  // reset behaves as a flush
  logic                  clear;
  // EXECUTE can take a new command
  logic                  exec_ready;
  // per slot resolved state
  logic                  free_a1;
  logic                  free_b1;
  rsrvs_pkg::operand_t   busy_rfa1;
  rsrvs_pkg::operand_t   busy_rfb1;
  // latched BUSY command
  rsrvs_pkg::op_t        busy_op;
  rsrvs_pkg::opc_t       busy_opc;
  // EXECUTE load select
  rsrvs_pkg::exec_src_e  exec_src;

  assign clear = rst_i | pipeline_flush_i;

  ////////////////////////////////////////////////////////////
  // operand slots
  ////////////////////////////////////////////////////////////

  // operand A1
  rsrvs_operand_slot u_slot_a1 (
    .cpu_clk_i      (cpu_clk),
    .clear_i        (clear),
    .load_i         (padv_rsrvs_i),
    .dcod_operand_i (dcod_req_i.rfa1),
    .dcod_hazard_i  (hazard_a1_i),
    .wrbk_i         (wrbk_i),
    .value_o        (busy_rfa1),
    .free_o         (free_a1)
  );

  // operand B1
  rsrvs_operand_slot u_slot_b1 (
    .cpu_clk_i      (cpu_clk),
    .clear_i        (clear),
    .load_i         (padv_rsrvs_i),
    .dcod_operand_i (dcod_req_i.rfb1),
    .dcod_hazard_i  (hazard_b1_i),
    .wrbk_i         (wrbk_i),
    .value_o        (busy_rfb1),
    .free_o         (free_b1)
  );

  ////////////////////////////////////////////////////////////
  // stages
  ////////////////////////////////////////////////////////////

  rsrvs_busy_stage u_busy_stage (
    .cpu_clk_i    (cpu_clk),
    .clear_i      (clear),
    .padv_rsrvs_i (padv_rsrvs_i),
    .exec_ready_i (exec_ready),
    .dcod_req_i   (dcod_req_i),
    .hazard_a1_i  (hazard_a1_i),
    .hazard_b1_i  (hazard_b1_i),
    .free_a1_i    (free_a1),
    .free_b1_i    (free_b1),
    .busy_op_o    (busy_op),
    .busy_opc_o   (busy_opc),
    .exec_src_o   (exec_src),
    .unit_free_o  (unit_free_o)
  );

  rsrvs_exec_stage u_exec_stage (
    .cpu_clk_i    (cpu_clk),
    .clear_i      (clear),
    .taking_op_i  (taking_op_i),
    .exec_src_i   (exec_src),
    .dcod_req_i   (dcod_req_i),
    .busy_op_i    (busy_op),
    .busy_opc_i   (busy_opc),
    .busy_rfa1_i  (busy_rfa1),
    .busy_rfb1_i  (busy_rfb1),
    .exec_ready_o (exec_ready),
    .exec_cmd_o   (exec_cmd_o)
  );

endmodule

`default_nettype wire

//--- rsrvs/rsrvs_exec_stage.sv
// EXECUTE stage latches

`timescale 1ns/1ps
`default_nettype none

module rsrvs_exec_stage (
  input  logic                  cpu_clk_i,
  // reset or flush
  input  logic                  clear_i,
  // unit consumes current contents
  input  logic                  taking_op_i,
  // load select from BUSY stage
  input  rsrvs_pkg::exec_src_e  exec_src_i,
  input  rsrvs_pkg::dcod_req_t  dcod_req_i,
  // BUSY command and forwarded operands
  input  rsrvs_pkg::op_t        busy_op_i,
  input  rsrvs_pkg::opc_t       busy_opc_i,
  input  rsrvs_pkg::operand_t   busy_rfa1_i,
  input  rsrvs_pkg::operand_t   busy_rfb1_i,
  output logic                  exec_ready_o,
  output rsrvs_pkg::exec_cmd_t  exec_cmd_o
);

  // EXECUTE holds a command
  logic exec_valid;

  // empty latches or unit taking them
  assign exec_ready_o = (~exec_valid) | taking_op_i;

  ////////////////////////////////////////////////////////////
  // command and attributes
  ////////////////////////////////////////////////////////////

  always_ff @(posedge cpu_clk_i) begin
    if (clear_i) begin
      exec_valid     <= 1'b0;
      exec_cmd_o.op  <= '0;
      exec_cmd_o.opc <= '0;
    end else begin
      case (exec_src_i)
        rsrvs_pkg::FROM_BUSY: begin
          exec_valid     <= 1'b1;
          exec_cmd_o.op  <= busy_op_i;
          exec_cmd_o.opc <= busy_opc_i;
        end
        rsrvs_pkg::FROM_DCOD: begin
          exec_valid     <= 1'b1;
          exec_cmd_o.op  <= dcod_req_i.op;
          exec_cmd_o.opc <= dcod_req_i.opc;
        end
        // bubble into the unit
        rsrvs_pkg::CLEAR: begin
          exec_valid     <= 1'b0;
          exec_cmd_o.op  <= '0;
          exec_cmd_o.opc <= '0;
        end
        default: begin
        end
      endcase
    end
  end

  ////////////////////////////////////////////////////////////
  // operands
  ////////////////////////////////////////////////////////////

  // stale values under a bubble, op_any tells
  always_ff @(posedge cpu_clk_i) begin
    case (exec_src_i)
      rsrvs_pkg::FROM_BUSY: begin
        exec_cmd_o.rfa1 <= busy_rfa1_i;
        exec_cmd_o.rfb1 <= busy_rfb1_i;
      end
      rsrvs_pkg::FROM_DCOD: begin
        exec_cmd_o.rfa1 <= dcod_req_i.rfa1;
        exec_cmd_o.rfb1 <= dcod_req_i.rfb1;
      end
      default: begin
      end
    endcase
  end

  // valid flag goes out every cycle
  assign exec_cmd_o.op_any = exec_valid;

endmodule

`default_nettype wire

//--- rsrvs/rsrvs_busy_stage.sv
// BUSY stage and load control

`timescale 1ns/1ps
`default_nettype none

module rsrvs_busy_stage (
  input  logic                  cpu_clk_i,
  // reset or flush
  input  logic                  clear_i,
  input  logic                  padv_rsrvs_i,
  // EXECUTE empty or being taken
  input  logic                  exec_ready_i,
  input  rsrvs_pkg::dcod_req_t  dcod_req_i,
  input  rsrvs_pkg::hazard_t    hazard_a1_i,
  input  rsrvs_pkg::hazard_t    hazard_b1_i,
  // slots resolved this cycle
  input  logic                  free_a1_i,
  input  logic                  free_b1_i,
  output rsrvs_pkg::op_t        busy_op_o,
  output rsrvs_pkg::opc_t       busy_opc_o,
  output rsrvs_pkg::exec_src_e  exec_src_o,
  output logic                  unit_free_o
);

  // pipe advance mode
  rsrvs_pkg::adv_mode_e adv_mode;
  // decode instruction waits on some operand
  logic dcod_hazard;
  // all BUSY operands resolved
  logic all_free;
  // BUSY occupancy
  logic busy_valid;
  // BUSY takes decode
  logic busy_take;
  // BUSY moves to EXECUTE
  logic busy_drain;

  assign adv_mode    = rsrvs_pkg::adv_mode_e'({exec_ready_i, padv_rsrvs_i});
  assign dcod_hazard = hazard_a1_i.d1 | hazard_a1_i.d2 |
                       hazard_b1_i.d1 | hazard_b1_i.d2;
  assign all_free    = free_a1_i & free_b1_i;

  // hazard insn or blocked EXECUTE parks in BUSY
  assign busy_take  = (adv_mode == rsrvs_pkg::ARRIVE) |
                      ((adv_mode == rsrvs_pkg::PASS) & dcod_hazard);
  assign busy_drain = (adv_mode == rsrvs_pkg::DRAIN) & busy_valid & all_free;

  ////////////////////////////////////////////////////////////
  // EXECUTE select
  ////////////////////////////////////////////////////////////

  always_comb begin
    case (adv_mode)
      rsrvs_pkg::HOLD,
      rsrvs_pkg::ARRIVE: exec_src_o = rsrvs_pkg::KEEP;
      // empty or unresolved BUSY leaves a bubble
      rsrvs_pkg::DRAIN:  exec_src_o = busy_drain ? rsrvs_pkg::FROM_BUSY : rsrvs_pkg::CLEAR;
      rsrvs_pkg::PASS:   exec_src_o = dcod_hazard ? rsrvs_pkg::CLEAR : rsrvs_pkg::FROM_DCOD;
      default:           exec_src_o = rsrvs_pkg::KEEP;
    endcase
  end

  ////////////////////////////////////////////////////////////
  // BUSY latches
  ////////////////////////////////////////////////////////////

  // occupancy
  always_ff @(posedge cpu_clk_i) begin
    if (clear_i) begin
      busy_valid <= 1'b0;
    end else if (busy_take) begin
      busy_valid <= 1'b1;
    end else if (busy_drain) begin
      busy_valid <= 1'b0;
    end
  end

  // command payload
  always_ff @(posedge cpu_clk_i) begin
    if (busy_take) begin
      busy_op_o  <= dcod_req_i.op;
      busy_opc_o <= dcod_req_i.opc;
    end
  end

  // decode may issue only into an empty BUSY
  assign unit_free_o = ~busy_valid;

endmodule

`default_nettype wire

//--- rsrvs/rsrvs_operand_slot.sv
// operand slot with write-back forwarding

`timescale 1ns/1ps
`default_nettype none

module rsrvs_operand_slot (
  input  logic                 cpu_clk_i,
  // reset or flush
  input  logic                 clear_i,
  // decode advances into the station
  input  logic                 load_i,
  input  rsrvs_pkg::operand_t  dcod_operand_i,
  input  rsrvs_pkg::hazard_t   dcod_hazard_i,
  // write-back snoop
  input  rsrvs_pkg::wrbk_t     wrbk_i,
  // forwarded operand value
  output rsrvs_pkg::operand_t  value_o,
  // no hazard left after this cycle
  output logic                 free_o
);

  ////////////////////////////////////////////////////////////
  // slot state
  ////////////////////////////////////////////////////////////

  // flags plus producer tag
  rsrvs_pkg::hazard_t   hazard_r;
  // stored operand
  rsrvs_pkg::operand_t  operand_r;

  // operand still waits for some producer
  logic waiting;
  // producer shows up on write-back now
  logic wrbk_match;

  assign waiting    = hazard_r.d1 | hazard_r.d2;
  // tag only meaningful with a raised flag
  assign wrbk_match = waiting & (hazard_r.extadr == wrbk_i.extadr);

  // resolved in this very cycle counts as free
  assign free_o = (~waiting) | wrbk_match;

  ////////////////////////////////////////////////////////////
  // forwarding mux
  ////////////////////////////////////////////////////////////

  // d1 selects result1, d2 selects result2
  always_comb begin
    if (hazard_r.d1) begin
      value_o = wrbk_i.result1;
    end else if (hazard_r.d2) begin
      value_o = wrbk_i.result2;
    end else begin
      value_o = operand_r;
    end
  end

  ////////////////////////////////////////////////////////////
  // hazard flags and tag
  ////////////////////////////////////////////////////////////

  always_ff @(posedge cpu_clk_i) begin
    if (clear_i) begin
      hazard_r.d1 <= 1'b0;
      hazard_r.d2 <= 1'b0;
    end else if (load_i) begin
      // new instruction, take decode flags and tag
      hazard_r <= dcod_hazard_i;
    end else if (wrbk_match) begin
      // producer written back, stop forwarding
      hazard_r.d1 <= 1'b0;
      hazard_r.d2 <= 1'b0;
    end
  end

  ////////////////////////////////////////////////////////////
  // operand register
  ////////////////////////////////////////////////////////////

  // re-latch the mux output so a match is captured
  always_ff @(posedge cpu_clk_i) begin
    if (load_i) begin
      operand_r <= dcod_operand_i;
    end else begin
      operand_r <= value_o;
    end
  end

endmodule

`default_nettype wire

//--- common/rsrvs_pkg.sv
// reservation station types

`default_nettype none

`include "rsrvs_defines.svh"

package rsrvs_pkg;

  ////////////////////////////////////////////////////////////
  // plain vectors
  ////////////////////////////////////////////////////////////

  typedef logic [`RSRVS_OPERAND_WIDTH-1:0] operand_t;
  typedef logic [`RSRVS_EXTADR_WIDTH-1:0]  extadr_t;
  typedef logic [`RSRVS_OP_WIDTH-1:0]      op_t;
  typedef logic [`RSRVS_OPC_WIDTH-1:0]     opc_t;

  ////////////////////////////////////////////////////////////
  // bundles
  ////////////////////////////////////////////////////////////

  // hazard of one operand, d1 and d2 are exclusive
  typedef struct packed {
    logic    d1;
    logic    d2;
    extadr_t extadr;
  } hazard_t;

  // request from decode
  typedef struct packed {
    op_t      op;
    opc_t     opc;
    operand_t rfa1;
    operand_t rfb1;
  } dcod_req_t;

  // write-back bus, valid every cycle
  typedef struct packed {
    extadr_t  extadr;
    operand_t result1;
    operand_t result2;
  } wrbk_t;

  // command and operands to the unit
  typedef struct packed {
    logic     op_any;
    op_t      op;
    opc_t     opc;
    operand_t rfa1;
    operand_t rfb1;
  } exec_cmd_t;

  ////////////////////////////////////////////////////////////
  // selects
  ////////////////////////////////////////////////////////////

  // what the EXECUTE latches take
  typedef enum logic [1:0] {
    KEEP      = 2'b00,
    FROM_BUSY = 2'b01,
    FROM_DCOD = 2'b10,
    CLEAR     = 2'b11
  } exec_src_e;

  // {exec_ready, padv_rsrvs}
  typedef enum logic [1:0] {
    HOLD   = 2'b00,
    ARRIVE = 2'b01,
    DRAIN  = 2'b10,
    PASS   = 2'b11
  } adv_mode_e;

endpackage

`default_nettype wire

//--- common/rsrvs_defines.svh
// reservation station widths

`ifndef RSRVS_DEFINES_SVH
`define RSRVS_DEFINES_SVH

////////////////////////////////////////////////////////////
// data path
////////////////////////////////////////////////////////////

// one operand, A1 or B1
`define RSRVS_OPERAND_WIDTH 32

// order control buffer tag, log2 of its depth
`define RSRVS_EXTADR_WIDTH 3

////////////////////////////////////////////////////////////
// command path
////////////////////////////////////////////////////////////

// unit command set
`define RSRVS_OP_WIDTH 4
// extra attributes for the command
`define RSRVS_OPC_WIDTH 2

`endif
